// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_ex_stage -o tb_ex_stage
	./obj_dir/tb_ex_stage | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb.f
verilog/riscv_pkg.sv
verilog/pipe_pkg.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/agu.sv
verilog/ex_ctrl.sv
verilog/ex_stage.sv
tests/tb_ex_stage.sv

// File: tests/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    localparam int CLK_PERIOD   = 40;
    localparam int ALU_CASES    = 11;
    localparam int BRANCH_CASES = 12;
    localparam int JUMP_CASES   = 3;
    localparam int MEM_CASES    = 8;
    localparam int RUN_CYCLES   = 4 + 2 * (ALU_CASES + BRANCH_CASES + JUMP_CASES + MEM_CASES) + 10;
    localparam int WATCHDOG_NS  = (RUN_CYCLES + 40) * CLK_PERIOD;

    logic                 clk = 1'b0;
    logic                 rst_i;
    pipe_pkg::ex_in_t     ex_in_i;
    pipe_pkg::ex_out_t    ex_out_o;
    pipe_pkg::redirect_t  redirect_o;

    logic [31:0]          lfsr_state = 32'd91;
    int                   err_count = 0;
    int                   check_count = 0;

    ex_stage u_dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .ex_in_i    (ex_in_i),
        .ex_out_o   (ex_out_o),
        .redirect_o (redirect_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand_bits(5);
        return r[4:0];
    endfunction

    function automatic pipe_pkg::ex_in_t make_instr(input riscv_pkg::alu_sel_e sel,
            input logic [31:0] o1, input logic [31:0] o2, input logic [31:0] o3,
            input logic [31:0] o4, input logic [4:0] wd, input logic wreg);
        pipe_pkg::ex_in_t t;
        t.valid   = 1'b1;
        t.alu_sel = sel;
        t.opr1    = o1;
        t.opr2    = o2;
        t.opr3    = o3;
        t.opr4    = o4;
        t.wd      = wd;
        t.wreg    = wreg;
        return t;
    endfunction

    function automatic pipe_pkg::ex_in_t idle_instr();
        pipe_pkg::ex_in_t t;
        t         = '0;
        t.alu_sel = riscv_pkg::SEL_NOP;
        return t;
    endfunction

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31]) begin
            return a[31];                          // Negative side is smaller.
        end
        return a < b;
    endfunction

    // Expected ALU result.
    function automatic logic [31:0] alu_model(input riscv_pkg::alu_sel_e sel,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] pc);
        logic [31:0] r;
        logic [4:0]  sh;
        sh = b[4:0];
        case (sel)
            riscv_pkg::SEL_OR:    r = a | b;
            riscv_pkg::SEL_AND:   r = a & b;
            riscv_pkg::SEL_XOR:   r = a ^ b;
            riscv_pkg::SEL_ADD:   r = a + b;
            riscv_pkg::SEL_SLT:   r = signed_less(a, b) ? 32'd1 : 32'd0;
            riscv_pkg::SEL_SLTU:  r = (a < b) ? 32'd1 : 32'd0;
            riscv_pkg::SEL_SLL:   r = a << sh;
            riscv_pkg::SEL_SRL: begin
                r = a >> sh;
                if (b[10] && a[31]) begin
                    r = r | ~(32'hffff_ffff >> sh); // Fill with the sign.
                end
            end
            riscv_pkg::SEL_LUI:   r = a;
            riscv_pkg::SEL_AUIPC: r = a + pc;
            default:              r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic logic [1:0] mem_size_of(input riscv_pkg::alu_sel_e sel);
        case (sel)
            riscv_pkg::SEL_LB, riscv_pkg::SEL_LBU, riscv_pkg::SEL_SB: return 2'd1;
            riscv_pkg::SEL_LH, riscv_pkg::SEL_LHU, riscv_pkg::SEL_SH: return 2'd2;
            riscv_pkg::SEL_LW, riscv_pkg::SEL_SW:                     return 2'd3;
            default:                                                  return 2'd0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_status(input logic exp_valid, input logic exp_wreg,
            input logic exp_taken, input logic [1:0] exp_size);
        check("ex_out_o.valid", 32'(exp_valid), 32'(ex_out_o.valid));
        check("ex_out_o.wreg", 32'(exp_wreg), 32'(ex_out_o.wreg));
        check("redirect_o.taken", 32'(exp_taken), 32'(redirect_o.taken));
        check("ex_out_o.mem.size", 32'(exp_size), 32'(ex_out_o.mem.size));
    endtask

    task automatic report_test(input string name, input int start);
        $display("Test %s finished with %0d errors", name, err_count - start);
    endtask

    // One instruction in, idle behind it, sample mid-cycle.
    task automatic apply_instr(input pipe_pkg::ex_in_t instr);
        @(posedge clk);
        ex_in_i <= instr;
        @(posedge clk);
        ex_in_i <= idle_instr();
        @(negedge clk);
    endtask

    task automatic reset_behavior();
        int start;
        start = err_count;
        @(posedge clk);
        @(negedge clk);
        check_status(1'b0, 1'b0, 1'b0, 2'd0);     // Inside reset.
        @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_status(1'b0, 1'b0, 1'b0, 2'd0);
        @(posedge clk);
        @(negedge clk);
        check_status(1'b0, 1'b0, 1'b0, 2'd0);     // First idle cycle after reset.
        report_test("reset", start);
    endtask

    task automatic alu_case(input riscv_pkg::alu_sel_e sel, input logic arith);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [4:0]  wd;
        a  = rand_bits(32);
        b  = rand_bits(32);
        pc = rand_bits(32) & 32'hffff_fffc;
        wd = rand_reg();
        if (sel == riscv_pkg::SEL_SRL) begin
            b[10] = arith;
            a[31] = 1'b1;                          // Negative value shows the fill.
            if (b[4:0] == 5'd0) begin
                b[0] = 1'b1;                       // A zero shift hides the fill.
            end
        end
        if (sel == riscv_pkg::SEL_SLT || sel == riscv_pkg::SEL_SLTU) begin
            b[31] = ~a[31];                        // Signed and unsigned order disagree.
        end
        apply_instr(make_instr(sel, a, b, 32'd0, pc, wd, 1'b1));
        check("ex_out_o.wdata", alu_model(sel, a, b, pc), ex_out_o.wdata);
        check("ex_out_o.wd", 32'(wd), 32'(ex_out_o.wd));
        check_status(1'b1, 1'b1, 1'b0, 2'd0);
    endtask

    task automatic alu_operations();
        int start;
        start = err_count;
        alu_case(riscv_pkg::SEL_OR, 1'b0);
        alu_case(riscv_pkg::SEL_AND, 1'b0);
        alu_case(riscv_pkg::SEL_XOR, 1'b0);
        alu_case(riscv_pkg::SEL_ADD, 1'b0);
        alu_case(riscv_pkg::SEL_SLT, 1'b0);
        alu_case(riscv_pkg::SEL_SLTU, 1'b0);
        alu_case(riscv_pkg::SEL_SLL, 1'b0);
        alu_case(riscv_pkg::SEL_SRL, 1'b0);
        alu_case(riscv_pkg::SEL_SRL, 1'b1);
        alu_case(riscv_pkg::SEL_LUI, 1'b0);
        alu_case(riscv_pkg::SEL_AUIPC, 1'b0);
        report_test("alu_operations", start);
    endtask

    task automatic branch_case(input riscv_pkg::alu_sel_e sel, input logic [31:0] a,
            input logic [31:0] b, input logic taken);
        logic [31:0] imm;
        logic [31:0] pc;
        imm = rand_bits(13) & 32'hffff_fffe;
        pc  = rand_bits(32) & 32'hffff_fffc;
        apply_instr(make_instr(sel, a, b, imm, pc, rand_reg(), 1'b0));
        check("redirect_o.npc", imm + pc, redirect_o.npc);
        check("ex_out_o.wdata", 32'd0, ex_out_o.wdata);
        check_status(1'b1, 1'b0, taken, 2'd0);
    endtask

    task automatic conditional_branches();
        logic [31:0] r;
        logic [31:0] neg;
        logic [31:0] pos;
        int          start;
        start = err_count;
        r     = rand_bits(32);
        neg   = r | 32'h8000_0000;
        pos   = r & 32'h7fff_ffff;
        branch_case(riscv_pkg::SEL_BEQ, r, r, 1'b1);
        branch_case(riscv_pkg::SEL_BEQ, r, r ^ 32'd1, 1'b0);
        branch_case(riscv_pkg::SEL_BNE, r, r ^ 32'd1, 1'b1);
        branch_case(riscv_pkg::SEL_BNE, r, r, 1'b0);
        branch_case(riscv_pkg::SEL_BLT, neg, pos, 1'b1);  // Signed and unsigned disagree.
        branch_case(riscv_pkg::SEL_BLT, pos, neg, 1'b0);
        branch_case(riscv_pkg::SEL_BGE, pos, neg, 1'b1);
        branch_case(riscv_pkg::SEL_BGE, neg, pos, 1'b0);
        branch_case(riscv_pkg::SEL_BLTU, pos, neg, 1'b1);
        branch_case(riscv_pkg::SEL_BLTU, neg, pos, 1'b0);
        branch_case(riscv_pkg::SEL_BGEU, neg, pos, 1'b1);
        branch_case(riscv_pkg::SEL_BGEU, pos, neg, 1'b0);
        report_test("conditional_branches", start);
    endtask

    task automatic jump_case(input riscv_pkg::alu_sel_e sel, input logic [31:0] a,
            input logic [31:0] b);
        logic [31:0] pc;
        logic [31:0] npc;
        pc = rand_bits(32) & 32'hffff_fffc;
        if (sel == riscv_pkg::SEL_JAL) begin
            npc = a + pc;
        end else begin
            npc = (a + b) & 32'hffff_fffe;
        end
        apply_instr(make_instr(sel, a, b, 32'd0, pc, rand_reg(), 1'b1));
        check("redirect_o.npc", npc, redirect_o.npc);
        check("ex_out_o.wdata", pc + 32'd4, ex_out_o.wdata);
        check_status(1'b1, 1'b1, 1'b1, 2'd0);
    endtask

    task automatic jumps();
        int start;
        start = err_count;
        jump_case(riscv_pkg::SEL_JAL, rand_bits(21) & 32'hffff_fffe, 32'd0);
        jump_case(riscv_pkg::SEL_JALR, rand_bits(32), rand_bits(12));
        jump_case(riscv_pkg::SEL_JALR, rand_bits(32) | 32'd1, rand_bits(12) & 32'hffff_fffe);
        report_test("jumps", start);
    endtask

    task automatic mem_case(input riscv_pkg::alu_sel_e sel);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic        store;
        a     = rand_bits(32);
        b     = rand_bits(32);
        c     = rand_bits(12);
        store = sel inside {riscv_pkg::SEL_SB, riscv_pkg::SEL_SH, riscv_pkg::SEL_SW};
        apply_instr(make_instr(sel, a, b, c, 32'h0000_1000, rand_reg(), !store));
        check("ex_out_o.mem.addr", store ? a + c : a + b, ex_out_o.mem.addr);
        check("ex_out_o.mem.write", 32'(store), 32'(ex_out_o.mem.write));
        check("ex_out_o.mem.signed_ld",
              32'(sel inside {riscv_pkg::SEL_LB, riscv_pkg::SEL_LH, riscv_pkg::SEL_LW}),
              32'(ex_out_o.mem.signed_ld));
        check("ex_out_o.wdata", store ? b : 32'd0, ex_out_o.wdata);
        check_status(1'b1, !store, 1'b0, mem_size_of(sel));
    endtask

    task automatic loads_stores();
        int start;
        start = err_count;
        mem_case(riscv_pkg::SEL_LB);
        mem_case(riscv_pkg::SEL_LH);
        mem_case(riscv_pkg::SEL_LW);
        mem_case(riscv_pkg::SEL_LBU);
        mem_case(riscv_pkg::SEL_LHU);
        mem_case(riscv_pkg::SEL_SB);
        mem_case(riscv_pkg::SEL_SH);
        mem_case(riscv_pkg::SEL_SW);
        report_test("loads_stores", start);
    endtask

    task automatic wrong_path_squash();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] pc;
        int          start;
        start = err_count;
        r  = rand_bits(32);
        a  = rand_bits(32);
        b  = rand_bits(32);
        c  = rand_bits(32);
        pc = rand_bits(32) & 32'hffff_fffc;
        @(posedge clk);
        ex_in_i <= make_instr(riscv_pkg::SEL_BEQ, r, r, 32'd64, pc, 5'd0, 1'b0);
        @(posedge clk);
        ex_in_i <= make_instr(riscv_pkg::SEL_ADD, a, b, 32'd0, pc + 32'd4, 5'd3, 1'b1);
        @(negedge clk);
        check("redirect_o.npc", pc + 32'd64, redirect_o.npc);
        check_status(1'b1, 1'b0, 1'b1, 2'd0);
        @(posedge clk);
        ex_in_i <= make_instr(riscv_pkg::SEL_ADD, b, c, 32'd0, pc + 32'd64, 5'd4, 1'b1);
        @(negedge clk);
        check_status(1'b0, 1'b0, 1'b0, 2'd0);     // Wrong-path ADD is dropped.
        @(posedge clk);
        ex_in_i <= idle_instr();
        @(negedge clk);
        check("ex_out_o.wdata", b + c, ex_out_o.wdata);
        check_status(1'b1, 1'b1, 1'b0, 2'd0);
        @(posedge clk);
        ex_in_i <= make_instr(riscv_pkg::SEL_BNE, r, r, 32'd64, pc, 5'd0, 1'b0);
        @(posedge clk);
        ex_in_i <= make_instr(riscv_pkg::SEL_ADD, a, b, 32'd0, pc + 32'd4, 5'd5, 1'b1);
        @(negedge clk);
        check_status(1'b1, 1'b0, 1'b0, 2'd0);
        @(posedge clk);
        ex_in_i <= idle_instr();
        @(negedge clk);
        check("ex_out_o.wdata", a + b, ex_out_o.wdata);
        check_status(1'b1, 1'b1, 1'b0, 2'd0);     // Not-taken branch kills nothing.
        report_test("wrong_path_squash", start);
    endtask

    initial begin
        rst_i   = 1'b1;
        ex_in_i = idle_instr();
        reset_behavior();
        alu_operations();
        conditional_branches();
        jumps();
        loads_stores();
        wrong_path_squash();
        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog/agu.sv
`timescale 1ns/1ps

module agu (
    input  riscv_pkg::alu_sel_e          alu_sel_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr1_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr2_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr3_i,
    output pipe_pkg::mem_req_t           mem_req_o
);

    logic [riscv_pkg::XLEN-1:0]  ld_addr;
    logic [riscv_pkg::XLEN-1:0]  st_addr;

    assign ld_addr = opr1_i + opr2_i;          // Base plus I-immediate.
    assign st_addr = opr1_i + opr3_i;          // Base plus S-immediate.

    always_comb begin
        mem_req_o.addr      = ld_addr;
        mem_req_o.write     = 1'b0;
        mem_req_o.size      = riscv_pkg::MEM_NONE;
        mem_req_o.signed_ld = 1'b0;
        case (alu_sel_i)
            riscv_pkg::SEL_LB, riscv_pkg::SEL_LBU: mem_req_o.size = riscv_pkg::MEM_BYTE;
            riscv_pkg::SEL_LH, riscv_pkg::SEL_LHU: mem_req_o.size = riscv_pkg::MEM_HALF;
            riscv_pkg::SEL_LW:                     mem_req_o.size = riscv_pkg::MEM_WORD;
            riscv_pkg::SEL_SB:                     mem_req_o.size = riscv_pkg::MEM_BYTE;
            riscv_pkg::SEL_SH:                     mem_req_o.size = riscv_pkg::MEM_HALF;
            riscv_pkg::SEL_SW:                     mem_req_o.size = riscv_pkg::MEM_WORD;
            default:                               mem_req_o.size = riscv_pkg::MEM_NONE;
        endcase
        if (alu_sel_i inside {riscv_pkg::SEL_LB, riscv_pkg::SEL_LH, riscv_pkg::SEL_LW}) begin
            mem_req_o.signed_ld = 1'b1;        // Sign-extend on return.
        end
        if (alu_sel_i inside {riscv_pkg::SEL_SB, riscv_pkg::SEL_SH, riscv_pkg::SEL_SW}) begin
            mem_req_o.addr  = st_addr;
            mem_req_o.write = 1'b1;
        end

        assert (!(mem_req_o.write && mem_req_o.size == riscv_pkg::MEM_NONE))
            else $error("agu: store request without an access size");
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  riscv_pkg::alu_sel_e          alu_sel_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr1_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr2_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr4_i,
    output logic [riscv_pkg::XLEN-1:0]   result_o
);

    logic [riscv_pkg::SHAMT_W-1:0]  shamt;
    logic                           arith;
    logic                           lt_signed;
    logic                           lt_unsigned;
    logic [riscv_pkg::XLEN-1:0]     shr_result;
    logic [riscv_pkg::XLEN-1:0]     link_addr;

    assign shamt       = opr2_i[riscv_pkg::SHAMT_W-1:0];
    assign arith       = opr2_i[10];     // Set for SRA and SRAI.
    assign lt_signed   = $signed(opr1_i) < $signed(opr2_i);
    assign lt_unsigned = opr1_i < opr2_i;
    assign link_addr   = opr4_i + riscv_pkg::XLEN'(riscv_pkg::INST_BYTES);

    // Arithmetic right shift when opr2 bit 10 is set.
    always_comb begin
        if (arith) begin
            shr_result = $signed(opr1_i) >>> shamt;
        end else begin
            shr_result = opr1_i >> shamt;
        end
    end

    always_comb begin
        case (alu_sel_i)
            riscv_pkg::SEL_OR: begin
                result_o = opr1_i | opr2_i;
            end
            riscv_pkg::SEL_AND: begin
                result_o = opr1_i & opr2_i;
            end
            riscv_pkg::SEL_XOR: begin
                result_o = opr1_i ^ opr2_i;
            end
            riscv_pkg::SEL_ADD: begin
                result_o = opr1_i + opr2_i;
            end
            riscv_pkg::SEL_SLT: begin
                result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_signed};   // 1 or 0.
            end
            riscv_pkg::SEL_SLTU: begin
                result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            riscv_pkg::SEL_SLL: begin
                result_o = opr1_i << shamt;
            end
            riscv_pkg::SEL_SRL: begin
                result_o = shr_result;
            end
            riscv_pkg::SEL_LUI: begin
                result_o = opr1_i;             // Immediate already shifted by decode.
            end
            riscv_pkg::SEL_AUIPC: begin
                result_o = opr1_i + opr4_i;
            end
            riscv_pkg::SEL_JAL, riscv_pkg::SEL_JALR: begin
                result_o = link_addr;          // Return address.
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  riscv_pkg::alu_sel_e          alu_sel_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr1_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr2_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr3_i,
    input  logic [riscv_pkg::XLEN-1:0]   opr4_i,
    output logic                         cond_met_o,
    output logic [riscv_pkg::XLEN-1:0]   target_o
);

    logic                        eq;
    logic                        lt_s;
    logic                        lt_u;
    logic [riscv_pkg::XLEN-1:0]  jalr_sum;

    assign eq       = opr1_i == opr2_i;
    assign lt_s     = $signed(opr1_i) < $signed(opr2_i);
    assign lt_u     = opr1_i < opr2_i;
    assign jalr_sum = opr1_i + opr2_i;

    always_comb begin
        cond_met_o = 1'b0;
        target_o   = opr3_i + opr4_i;          // PC-relative branch target.
        case (alu_sel_i)
            riscv_pkg::SEL_BEQ:  cond_met_o = eq;
            riscv_pkg::SEL_BNE:  cond_met_o = !eq;
            riscv_pkg::SEL_BLT:  cond_met_o = lt_s;
            riscv_pkg::SEL_BGE:  cond_met_o = !lt_s;
            riscv_pkg::SEL_BLTU: cond_met_o = lt_u;
            riscv_pkg::SEL_BGEU: cond_met_o = !lt_u;
            riscv_pkg::SEL_JAL:  target_o   = opr1_i + opr4_i;
            riscv_pkg::SEL_JALR: target_o   = {jalr_sum[riscv_pkg::XLEN-1:1], 1'b0};
            default: begin
                cond_met_o = 1'b0;
            end
        endcase

        // Fetch expects halfword-aligned register jumps.
        if (alu_sel_i == riscv_pkg::SEL_JALR) begin
            assert (target_o[0] == 1'b0)
                else $error("branch_unit: JALR target has bit 0 set");
        end
    end

endmodule

// File: verilog/ex_ctrl.sv
`timescale 1ns/1ps

module ex_ctrl (
    input  logic                         clk,
    input  logic                         rst_i,
    input  pipe_pkg::ex_in_t             ex_in_i,
    output riscv_pkg::alu_sel_e          alu_sel_o,
    input  logic [riscv_pkg::XLEN-1:0]   alu_result_i,
    input  logic                         cond_met_i,
    input  logic [riscv_pkg::XLEN-1:0]   target_i,
    input  pipe_pkg::mem_req_t           mem_req_i,
    output pipe_pkg::ex_out_t            ex_out_o,
    output pipe_pkg::redirect_t          redirect_o
);

    riscv_pkg::op_class_e  op_class;
    logic                  issue;
    logic                  mem_en;
    logic                  squash_q;         // Previous cycle raised a redirect.
    pipe_pkg::ex_out_t     out_nxt;
    pipe_pkg::ex_out_t     out_q;
    pipe_pkg::redirect_t   redir_nxt;
    pipe_pkg::redirect_t   redir_q;

    assign alu_sel_o = ex_in_i.alu_sel;
    assign issue     = ex_in_i.valid && !squash_q; // Wrong-path slot is dropped.

    always_comb begin
        case (ex_in_i.alu_sel)
            riscv_pkg::SEL_OR, riscv_pkg::SEL_AND, riscv_pkg::SEL_XOR, riscv_pkg::SEL_ADD,
            riscv_pkg::SEL_SLT, riscv_pkg::SEL_SLTU, riscv_pkg::SEL_SLL, riscv_pkg::SEL_SRL,
            riscv_pkg::SEL_LUI, riscv_pkg::SEL_AUIPC:
                op_class = riscv_pkg::CLS_ALU;
            riscv_pkg::SEL_JAL, riscv_pkg::SEL_JALR:
                op_class = riscv_pkg::CLS_JUMP;
            riscv_pkg::SEL_BEQ, riscv_pkg::SEL_BNE, riscv_pkg::SEL_BLT, riscv_pkg::SEL_BGE,
            riscv_pkg::SEL_BLTU, riscv_pkg::SEL_BGEU:
                op_class = riscv_pkg::CLS_BRANCH;
            riscv_pkg::SEL_LB, riscv_pkg::SEL_LH, riscv_pkg::SEL_LW, riscv_pkg::SEL_LBU,
            riscv_pkg::SEL_LHU:
                op_class = riscv_pkg::CLS_LOAD;
            riscv_pkg::SEL_SB, riscv_pkg::SEL_SH, riscv_pkg::SEL_SW:
                op_class = riscv_pkg::CLS_STORE;
            default:
                op_class = riscv_pkg::CLS_NONE;
        endcase
    end

    assign mem_en = issue && (op_class == riscv_pkg::CLS_LOAD ||
                              op_class == riscv_pkg::CLS_STORE);

    always_comb begin
        out_nxt       = '0;
        out_nxt.valid = issue;
        out_nxt.wd    = ex_in_i.wd;
        out_nxt.wreg  = issue && ex_in_i.wreg;
        case (op_class)
            riscv_pkg::CLS_ALU, riscv_pkg::CLS_JUMP: out_nxt.wdata = alu_result_i;
            riscv_pkg::CLS_STORE:                    out_nxt.wdata = ex_in_i.opr2;
            default:                                 out_nxt.wdata = '0;
        endcase
        out_nxt.mem       = mem_req_i;
        out_nxt.mem.write = mem_en && mem_req_i.write;
        if (!mem_en) begin
            out_nxt.mem.size = riscv_pkg::MEM_NONE;
        end

        redir_nxt.taken = issue && (op_class == riscv_pkg::CLS_JUMP ||
                                    (op_class == riscv_pkg::CLS_BRANCH && cond_met_i));
        redir_nxt.npc   = target_i;
    end

    always_ff @(posedge clk) begin
        out_q    <= out_nxt;
        redir_q  <= redir_nxt;
        squash_q <= redir_nxt.taken;
        if (rst_i) begin
            out_q.valid    <= 1'b0;
            out_q.wreg     <= 1'b0;
            out_q.mem.size <= riscv_pkg::MEM_NONE;
            out_q.mem.write <= 1'b0;
            redir_q.taken  <= 1'b0;
            squash_q       <= 1'b0;
        end
    end

    assign ex_out_o   = out_q;
    assign redirect_o = redir_q;

    // A redirect always travels with its own instruction.
    a_taken_valid: assert property (@(posedge clk) disable iff (rst_i)
        redirect_o.taken |-> ex_out_o.valid);

    // The slot behind a redirect leaves no trace.
    a_squash_kill: assert property (@(posedge clk) disable iff (rst_i)
        squash_q |=> !ex_out_o.valid && !ex_out_o.wreg && !redirect_o.taken);

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  pipe_pkg::ex_in_t      ex_in_i,
    output pipe_pkg::ex_out_t     ex_out_o,
    output pipe_pkg::redirect_t   redirect_o
);

    riscv_pkg::alu_sel_e          alu_sel;
    logic [riscv_pkg::XLEN-1:0]   alu_result;
    logic                         cond_met;
    logic [riscv_pkg::XLEN-1:0]   target;
    pipe_pkg::mem_req_t           mem_req;

    ex_ctrl u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .ex_in_i      (ex_in_i),
        .alu_sel_o    (alu_sel),
        .alu_result_i (alu_result),
        .cond_met_i   (cond_met),
        .target_i     (target),
        .mem_req_i    (mem_req),
        .ex_out_o     (ex_out_o),
        .redirect_o   (redirect_o)
    );

    alu u_alu (
        .alu_sel_i (alu_sel),
        .opr1_i    (ex_in_i.opr1),
        .opr2_i    (ex_in_i.opr2),
        .opr4_i    (ex_in_i.opr4),
        .result_o  (alu_result)
    );

    branch_unit u_branch (
        .alu_sel_i  (alu_sel),
        .opr1_i     (ex_in_i.opr1),
        .opr2_i     (ex_in_i.opr2),
        .opr3_i     (ex_in_i.opr3),
        .opr4_i     (ex_in_i.opr4),
        .cond_met_o (cond_met),
        .target_o   (target)
    );

    agu u_agu (
        .alu_sel_i (alu_sel),
        .opr1_i    (ex_in_i.opr1),
        .opr2_i    (ex_in_i.opr2),
        .opr3_i    (ex_in_i.opr3),
        .mem_req_o (mem_req)
    );

endmodule

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    // Decoded instruction entering execute.
    typedef struct packed {
        logic                                valid;
        riscv_pkg::alu_sel_e                 alu_sel;
        logic [riscv_pkg::XLEN-1:0]          opr1;     // Rs1, or upper immediate for LUI.
        logic [riscv_pkg::XLEN-1:0]          opr2;     // Rs2 or I-immediate.
        logic [riscv_pkg::XLEN-1:0]          opr3;     // Branch or store immediate.
        logic [riscv_pkg::XLEN-1:0]          opr4;     // Instruction PC.
        logic [riscv_pkg::REG_ADDR_W-1:0]    wd;
        logic                                wreg;
    } ex_in_t;

    // Request toward the data memory.
    typedef struct packed {
        logic [riscv_pkg::XLEN-1:0]          addr;
        logic                                write;    // 1 for store, 0 for load.
        riscv_pkg::mem_size_e                size;
        logic                                signed_ld;
    } mem_req_t;

    // Registered result toward the memory stage.
    typedef struct packed {
        logic                                valid;
        logic [riscv_pkg::REG_ADDR_W-1:0]    wd;
        logic                                wreg;
        logic [riscv_pkg::XLEN-1:0]          wdata;    // Result, link or store data.
        mem_req_t                            mem;
    } ex_out_t;

    // Fetch redirect.
    typedef struct packed {
        logic                                taken;
        logic [riscv_pkg::XLEN-1:0]          npc;
    } redirect_t;

endpackage

// File: verilog/riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN       = 32;           // Data and address width.
    localparam int REG_ADDR_W = 5;            // Register index width.
    localparam int SHAMT_W    = 5;            // Shift amount width for RV32.
    localparam int INST_BYTES = 4;            // Bytes per instruction.

    localparam int ALU_SEL_W  = 5;
    localparam int OP_CLASS_W = 3;
    localparam int MEM_SIZE_W = 2;

    // Operation select produced by decode.
    typedef enum logic [ALU_SEL_W-1:0] {
        SEL_OR,
        SEL_AND,
        SEL_XOR,
        SEL_ADD,
        SEL_SLT,
        SEL_SLTU,
        SEL_SLL,
        SEL_SRL,                              // Arithmetic when opr2 bit 10 is set.
        SEL_LUI,
        SEL_AUIPC,
        SEL_JAL,
        SEL_JALR,
        SEL_BEQ,
        SEL_BNE,
        SEL_BLT,
        SEL_BGE,
        SEL_BLTU,
        SEL_BGEU,
        SEL_LB,
        SEL_LH,
        SEL_LW,
        SEL_LBU,
        SEL_LHU,
        SEL_SB,
        SEL_SH,
        SEL_SW,
        SEL_NOP
    } alu_sel_e;

    // Unit that owns a select.
    typedef enum logic [OP_CLASS_W-1:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_LOAD,
        CLS_STORE,
        CLS_NONE
    } op_class_e;

    // Memory access size where zero means no access.
    typedef enum logic [MEM_SIZE_W-1:0] {
        MEM_NONE = 2'd0,
        MEM_BYTE = 2'd1,
        MEM_HALF = 2'd2,
        MEM_WORD = 2'd3
    } mem_size_e;

endpackage
